// File: fft_stream_adapter.f
fft_stream_pkg.sv
sample_fifo.sv
frame_beat_counter.sv
frame_ctrl.sv
spectrum_unpack.sv
fft_stream_adapter.sv
fft_stream_adapter_chk.sv
fft_stream_adapter_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := fft_stream_adapter_tb
FILELIST := fft_stream_adapter.f
LOG      := sim.log
FAIL_MSG := Test failed
PASS_MSG := Test passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: fft_stream_adapter_tb.sv
module fft_stream_adapter_tb;

    localparam int STIM_CYCLES    = 3000;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 1000;  // drain margin
    localparam int FRAME_LEN      = fft_stream_pkg::FRAME_LEN;
    localparam int FIFO_DEPTH     = fft_stream_pkg::FIFO_DEPTH;

    logic                     clk;
    logic                     rst_n;
    logic                     wr_en;
    fft_stream_pkg::sample_t  wr_data;
    logic                     drop;
    logic                     in_tvalid;
    fft_stream_pkg::fft_in_t  in_tdata;
    logic                     in_tlast;
    logic                     in_tready;
    logic                     out_tvalid;
    fft_stream_pkg::fft_out_t out_tdata;
    logic                     out_tlast;
    logic                     spec_valid;
    fft_stream_pkg::fft_out_t spec;
    logic                     sop;
    logic                     eop;

    integer seed;
    int     cycle_cnt = 0;

    // reference model of the sample path
    fft_stream_pkg::sample_t fifo_q [$];
    bit exp_stream  = 1'b0;  // frame being streamed
    int beat_idx    = 0;
    bit exp_drop    = 1'b0;
    int frames_sent = 0;
    int drop_cnt    = 0;

    // reference model of the result path
    bit prev_out_valid = 1'b0;
    bit prev_out_last  = 1'b0;
    bit prev_sof       = 1'b0;
    bit sof_pending    = 1'b1;
    bit spec_seen      = 1'b0;
    fft_stream_pkg::fft_out_t held_spec;

    // core stand-in and write burst state
    int core_beat  = 0;
    int core_gap   = 0;
    int burst_left = 0;
    int write_pct  = 0;

    fft_stream_adapter u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_wr_en      (wr_en),
        .i_wr_data    (wr_data),
        .o_drop       (drop),
        .o_in_tvalid  (in_tvalid),
        .o_in_tdata   (in_tdata),
        .o_in_tlast   (in_tlast),
        .i_in_tready  (in_tready),
        .i_out_tvalid (out_tvalid),
        .i_out_tdata  (out_tdata),
        .i_out_tlast  (out_tlast),
        .o_spec_valid (spec_valid),
        .o_spec       (spec),
        .o_sop        (sop),
        .o_eop        (eop)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic end_in_failure();
        $display("Test failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("error %s expected %h got %h", name, exp_v, act_v);
            end_in_failure();
        end
    endtask

    function automatic int rand_pct();
        return int'($unsigned($random(seed)) % 100);
    endfunction

    // called at each rising edge, before new inputs are driven
    task automatic step_model();
        bit xfer;
        bit exp_last;
        xfer     = in_tvalid && in_tready;
        exp_last = exp_stream && (beat_idx == FRAME_LEN - 1);
        check_val("o_in_tvalid", 64'(exp_stream), 64'(in_tvalid));
        check_val("o_in_tlast", 64'(exp_last), 64'(in_tlast));
        check_val("o_drop", 64'(exp_drop), 64'(drop));
        if (xfer) begin
            if (fifo_q.size() == 0) begin
                $display("a beat was sent to the core with no sample buffered");
                end_in_failure();
            end
            check_val("o_in_tdata.re", 64'(fifo_q[0]), 64'(in_tdata.re));
            check_val("o_in_tdata.im", 64'h0, 64'(in_tdata.im));
        end
        check_val("o_spec_valid", 64'(prev_out_valid), 64'(spec_valid));
        check_val("o_sop", 64'(prev_out_valid && prev_sof), 64'(sop));
        check_val("o_eop", 64'(prev_out_valid && prev_out_last), 64'(eop));
        if (spec_seen) check_val("o_spec", 64'(held_spec), 64'(spec));

        // advance from pre-edge occupancy
        exp_drop = wr_en && (fifo_q.size() == FIFO_DEPTH);
        if (exp_drop) drop_cnt++;
        if (!exp_stream) begin
            if (fifo_q.size() >= FRAME_LEN) exp_stream = 1'b1;
        end else if (xfer) begin
            if (beat_idx == FRAME_LEN - 1) begin
                exp_stream = 1'b0;  // idle cycle between frames
                beat_idx   = 0;
                frames_sent++;
            end else begin
                beat_idx++;
            end
        end
        if (xfer) void'(fifo_q.pop_front());
        if (wr_en && !exp_drop) fifo_q.push_back(wr_data);

        prev_out_valid = out_tvalid;
        prev_out_last  = out_tlast;
        prev_sof       = sof_pending;
        if (out_tvalid) begin
            held_spec   = out_tdata;
            spec_seen   = 1'b1;
            sof_pending = out_tlast;
        end
    endtask

    // writes come in bursts, heavy ones fill the fifo
    task automatic drive_writes(input bit active);
        if (burst_left == 0) begin
            burst_left = 40 + int'($unsigned($random(seed)) % 120);
            write_pct  = (rand_pct() < 50) ? 100 : 30;
        end
        burst_left--;
        wr_en   <= active && (rand_pct() < write_pct);
        wr_data <= 16'($random(seed));
    endtask

    // plays the FFT core, input ready and result side
    task automatic drive_core(input bit active);
        in_tready <= (rand_pct() < 70);
        if (core_gap > 0) begin
            out_tvalid <= 1'b0;
            out_tlast  <= 1'b0;
            core_gap--;
        end else if ((core_beat == 0 && !active) || (core_beat != 0 && rand_pct() < 15)) begin
            out_tvalid <= 1'b0;  // no new frame, or a hole inside one
            out_tlast  <= 1'b0;
        end else begin
            out_tvalid <= 1'b1;
            out_tdata  <= {$random(seed), $random(seed)};
            out_tlast  <= (core_beat == FRAME_LEN - 1);
            if (core_beat == FRAME_LEN - 1) begin
                core_beat = 0;
                core_gap  = int'($unsigned($random(seed)) % 5);  // zero gives back-to-back
            end else begin
                core_beat++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_in_failure();
        end
    end

    initial begin
        seed       = 37;
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_data    = '0;
        in_tready  = 1'b0;
        out_tvalid = 1'b0;
        out_tdata  = '0;
        out_tlast  = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // quiet outputs straight after reset
        check_val("o_in_tvalid", 64'h0, 64'(in_tvalid));
        check_val("o_in_tlast", 64'h0, 64'(in_tlast));
        check_val("o_spec_valid", 64'h0, 64'(spec_valid));
        check_val("o_sop", 64'h0, 64'(sop));
        check_val("o_eop", 64'h0, 64'(eop));
        check_val("o_drop", 64'h0, 64'(drop));

        for (int i = 0; i < STIM_CYCLES; i++) begin
            step_model();
            drive_writes(1'b1);
            drive_core(1'b1);
            @(posedge clk);
        end

        // let buffered frames and the last core frame come out
        step_model();
        drive_writes(1'b0);
        drive_core(1'b0);
        while (exp_stream || fifo_q.size() >= FRAME_LEN || core_beat != 0 ||
               prev_out_valid || exp_drop) begin
            @(posedge clk);
            step_model();
            drive_writes(1'b0);
            drive_core(1'b0);
        end

        $display("frames sent %0d, samples dropped %0d", frames_sent, drop_cnt);
        $display("Test passed");
        $finish;
    end

endmodule

// File: fft_stream_adapter_chk.sv
module fft_stream_adapter_chk (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    i_in_tvalid,
    input fft_stream_pkg::fft_in_t i_in_tdata,
    input logic                    i_in_tready,
    input logic                    i_in_tlast,
    input logic                    i_spec_valid,
    input logic                    i_sop,
    input logic                    i_eop
);

    // a stalled beat keeps valid and data
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (i_in_tvalid && !i_in_tready) |=> (i_in_tvalid && $stable(i_in_tdata)))
        else $error("stalled beat changed before it transferred");

    // idle cycle after the last beat of a frame
    a_last: assert property (@(posedge clk) disable iff (!rst_n)
        (i_in_tvalid && i_in_tready && i_in_tlast) |=> !i_in_tvalid)
        else $error("tvalid stayed high after the tlast beat transferred");

    // no start marker straight after a mid-frame result
    a_marks: assert property (@(posedge clk) disable iff (!rst_n)
        (i_spec_valid && !i_eop) |=> !i_sop)
        else $error("sop high right after a result without eop");

endmodule

bind fft_stream_adapter fft_stream_adapter_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_in_tvalid  (o_in_tvalid),
    .i_in_tdata   (o_in_tdata),
    .i_in_tready  (i_in_tready),
    .i_in_tlast   (o_in_tlast),
    .i_spec_valid (o_spec_valid),
    .i_sop        (o_sop),
    .i_eop        (o_eop)
);

// File: fft_stream_adapter.sv
module fft_stream_adapter (
    input  logic                     clk,
    input  logic                     rst_n,
    // sample input
    input  logic                     i_wr_en,
    input  fft_stream_pkg::sample_t  i_wr_data,
    output logic                     o_drop,
    // frames towards the core
    output logic                     o_in_tvalid,
    output fft_stream_pkg::fft_in_t  o_in_tdata,
    output logic                     o_in_tlast,
    input  logic                     i_in_tready,
    // results from the core
    input  logic                     i_out_tvalid,
    input  fft_stream_pkg::fft_out_t i_out_tdata,
    input  logic                     i_out_tlast,
    output logic                     o_spec_valid,
    output fft_stream_pkg::fft_out_t o_spec,
    output logic                     o_sop,
    output logic                     o_eop
);

    fft_stream_pkg::sample_t          fifo_head;
    logic [fft_stream_pkg::LVL_W-1:0] fifo_level;
    logic                             fifo_rd;
    logic                             beat;
    logic                             beat_clear;
    logic                             beat_last;

    sample_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr_en   (i_wr_en),
        .i_wr_data (i_wr_data),
        .i_rd_en   (fifo_rd),
        .o_rd_data (fifo_head),
        .o_empty   (),
        .o_level   (fifo_level),
        .o_drop    (o_drop)
    );

    frame_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_level     (fifo_level),
        .i_head      (fifo_head),
        .i_in_tready (i_in_tready),
        .i_last      (beat_last),
        .o_rd_en     (fifo_rd),
        .o_beat      (beat),
        .o_clear     (beat_clear),
        .o_in_tvalid (o_in_tvalid),
        .o_in_tdata  (o_in_tdata),
        .o_in_tlast  (o_in_tlast)
    );

    frame_beat_counter u_cnt (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_beat  (beat),
        .i_clear (beat_clear),
        .o_last  (beat_last)
    );

    spectrum_unpack u_unpack (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_out_tvalid (i_out_tvalid),
        .i_out_tdata  (i_out_tdata),
        .i_out_tlast  (i_out_tlast),
        .o_spec_valid (o_spec_valid),
        .o_spec       (o_spec),
        .o_sop        (o_sop),
        .o_eop        (o_eop)
    );

endmodule

// File: spectrum_unpack.sv
module spectrum_unpack (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_out_tvalid,
    input  fft_stream_pkg::fft_out_t i_out_tdata,
    input  logic                     i_out_tlast,
    output logic                     o_spec_valid,
    output fft_stream_pkg::fft_out_t o_spec,
    output logic                     o_sop,
    output logic                     o_eop
);

    // next valid beat opens a new frame
    logic sof_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sof_pending <= 1'b1;
        end else if (i_out_tvalid) begin
            sof_pending <= i_out_tlast;  // a tlast beat re-arms the start
        end
    end

    // flags, one cycle behind the core beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_spec_valid <= 1'b0;
            o_sop        <= 1'b0;
            o_eop        <= 1'b0;
        end else begin
            o_spec_valid <= i_out_tvalid;
            o_sop        <= i_out_tvalid && sof_pending;
            o_eop        <= i_out_tvalid && i_out_tlast;
        end
    end

    // result held between valid beats
    always_ff @(posedge clk) begin
        if (i_out_tvalid) begin
            o_spec <= i_out_tdata;
        end
    end

endmodule

// File: frame_ctrl.sv
module frame_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [fft_stream_pkg::LVL_W-1:0] i_level,
    input  fft_stream_pkg::sample_t          i_head,
    input  logic                             i_in_tready,
    input  logic                             i_last,
    output logic                             o_rd_en,
    output logic                             o_beat,
    output logic                             o_clear,
    output logic                             o_in_tvalid,
    output fft_stream_pkg::fft_in_t          o_in_tdata,
    output logic                             o_in_tlast
);

    fft_stream_pkg::frame_state_t state;
    fft_stream_pkg::frame_state_t state_nxt;

    logic frame_ready;
    logic xfer;

    // only start once the whole frame sits in the fifo,
    // so the head never runs dry mid-frame
    assign frame_ready = (i_level >= fft_stream_pkg::LVL_W'(fft_stream_pkg::FRAME_LEN));

    assign o_in_tvalid = (state == fft_stream_pkg::STREAM);
    assign xfer        = o_in_tvalid && i_in_tready;
    assign o_in_tlast  = o_in_tvalid && i_last;

    // real sample into the low half, imaginary part zero
    assign o_in_tdata.re = i_head;
    assign o_in_tdata.im = '0;

    // each transfer pops the fifo and steps the counter
    assign o_rd_en = xfer;
    assign o_beat  = xfer;
    assign o_clear = xfer && i_last;  // frame done

    always_comb begin
        state_nxt = state;
        case (state)
            fft_stream_pkg::IDLE: begin
                if (frame_ready) state_nxt = fft_stream_pkg::STREAM;
            end
            fft_stream_pkg::STREAM: begin
                if (xfer && i_last) state_nxt = fft_stream_pkg::IDLE;  // gap between frames
            end
            default: state_nxt = fft_stream_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fft_stream_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// File: frame_beat_counter.sv
module frame_beat_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic i_beat,
    input  logic i_clear,
    output logic o_last
);

    logic [fft_stream_pkg::BEAT_W-1:0] cnt;

    // beats transferred so far in this frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (i_clear) begin
            cnt <= '0;  // clear wins over the final beat
        end else if (i_beat) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_last = (cnt == fft_stream_pkg::BEAT_W'(fft_stream_pkg::FRAME_LEN - 1));

endmodule

// File: sample_fifo.sv
module sample_fifo (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_wr_en,
    input  fft_stream_pkg::sample_t         i_wr_data,
    input  logic                            i_rd_en,
    output fft_stream_pkg::sample_t         o_rd_data,
    output logic                            o_empty,
    output logic [fft_stream_pkg::LVL_W-1:0] o_level,
    output logic                            o_drop
);

    fft_stream_pkg::sample_t mem [fft_stream_pkg::FIFO_DEPTH];

    logic [fft_stream_pkg::PTR_W-1:0] wr_ptr;
    logic [fft_stream_pkg::PTR_W-1:0] rd_ptr;
    logic [fft_stream_pkg::LVL_W-1:0] level;
    logic                             full;
    logic                             wr_ok;
    logic                             rd_ok;

    assign full    = (level == fft_stream_pkg::LVL_W'(fft_stream_pkg::FIFO_DEPTH));
    assign o_empty = (level == '0);
    assign o_level = level;

    // a write at full is refused even if a read happens in the same cycle
    assign wr_ok = i_wr_en && !full;
    assign rd_ok = i_rd_en && !o_empty;

    // head shown without a read request
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;  // none, or push and pop together
            endcase
        end
    end

    // one-cycle pulse after a refused write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_drop <= 1'b0;
        end else begin
            o_drop <= i_wr_en && full;
        end
    end

endmodule

// File: fft_stream_pkg.sv
package fft_stream_pkg;

    // sample and result widths
    localparam int DIN_W  = 16;  // real input sample
    localparam int DOUT_W = 32;  // one component of a core result

    // frame and buffer sizing
    localparam int FRAME_LEN  = 16;
    localparam int FIFO_DEPTH = 32;  // two frames of buffering

    localparam int PTR_W  = $clog2(FIFO_DEPTH);      // fifo address
    localparam int LVL_W  = $clog2(FIFO_DEPTH + 1);  // holds 0..FIFO_DEPTH
    localparam int BEAT_W = $clog2(FRAME_LEN);       // holds 0..FRAME_LEN-1

    typedef logic [DIN_W-1:0] sample_t;

    // beat towards the core, imaginary part on top
    typedef struct packed {
        logic [DIN_W-1:0] im;
        logic [DIN_W-1:0] re;
    } fft_in_t;

    // beat from the core, same layout at output width
    typedef struct packed {
        logic [DOUT_W-1:0] im;
        logic [DOUT_W-1:0] re;
    } fft_out_t;

    // frame_ctrl states
    typedef enum logic {
        IDLE,    // waiting for a whole frame in the fifo
        STREAM   // sending a frame to the core
    } frame_state_t;

endpackage
